//--- src.f
+incdir+src
src/ooo_pkg.sv
src/register_alias_table.sv
src/reservation_station.sv
src/int_exec_unit.sv
src/ooo_core.sv
tb/ooo_checker.sv
tb/tb_ooo_core.sv

//--- src/int_exec_unit.sv
`timescale 1ns/1ps
`include "ooo_macros.svh"

module int_exec_unit (
    input  logic                   clk,
    input  logic                   rst,
    // Dispatch handshake
    input  logic                   disp_valid,
    output logic                   disp_ready,
    input  ooo_pkg::alu_op_t       disp_op,
    input  logic [`OOO_DATA_W-1:0] disp_a,
    input  logic [`OOO_DATA_W-1:0] disp_b,
    input  logic [`OOO_TAG_W-1:0]  disp_tag,
    // Result broadcast
    output logic                   cdb_valid,
    output logic [`OOO_TAG_W-1:0]  cdb_tag,
    output logic [`OOO_DATA_W-1:0] cdb_value
);

    localparam int CNT_W = $clog2(`OOO_MUL_STEPS);

    ooo_pkg::mul_state_t    mul_state;
    logic [CNT_W-1:0]       mul_cnt;    // Steps already taken
    logic [`OOO_DATA_W-1:0] mul_acc;    // Partial product sum
    logic [`OOO_DATA_W-1:0] mul_mcand;  // Multiplicand, pre-shifted per step
    logic [`OOO_DATA_W-1:0] mul_mplier; // Remaining multiplier bits
    logic [`OOO_TAG_W-1:0]  mul_tag;
    logic [`OOO_DATA_W-1:0] alu_res;
    logic                   disp_fire;

    // One step worth of shift-add, 4 multiplier bits
    function automatic logic [`OOO_DATA_W-1:0] nibble_pp(
        input logic [`OOO_DATA_W-1:0] m,
        input logic [3:0]             n
    );
        logic [`OOO_DATA_W-1:0] sum;
        sum = '0;
        for (int j = 0; j < 4; j++) begin
            if (n[j])
                sum = sum + (m << j);
        end
        return sum;
    endfunction

    assign disp_ready = (mul_state == ooo_pkg::MUL_IDLE);
    assign disp_fire  = disp_valid && disp_ready;

    // Single-cycle ops
    always_comb begin
        case (disp_op)
            ooo_pkg::OP_ADD: alu_res = disp_a + disp_b;
            ooo_pkg::OP_SUB: alu_res = disp_a - disp_b;
            ooo_pkg::OP_AND: alu_res = disp_a & disp_b;
            ooo_pkg::OP_XOR: alu_res = disp_a ^ disp_b;
            default:         alu_res = disp_a;  // LDI carries imm in a
        endcase
    end

    // ------------------------------------------------------------
    // Result stage and multiplier FSM
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            mul_state <= ooo_pkg::MUL_IDLE;
            mul_cnt   <= '0;
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= 1'b0;  // One-cycle pulse per result
            if (disp_fire && disp_op == ooo_pkg::OP_MUL) begin
                // First step taken on the dispatch edge itself
                mul_state  <= ooo_pkg::MUL_BUSY;
                mul_cnt    <= CNT_W'(1);
                mul_acc    <= nibble_pp(disp_a, disp_b[3:0]);
                mul_mcand  <= disp_a << 4;
                mul_mplier <= disp_b >> 4;
                mul_tag    <= disp_tag;
            end else if (disp_fire) begin
                cdb_valid <= 1'b1;
                cdb_tag   <= disp_tag;
                cdb_value <= alu_res;
            end else if (mul_state == ooo_pkg::MUL_BUSY) begin
                if (mul_cnt == CNT_W'(`OOO_MUL_STEPS - 1)) begin
                    cdb_valid <= 1'b1;  // Last step goes straight to the CDB
                    cdb_tag   <= mul_tag;
                    cdb_value <= mul_acc + nibble_pp(mul_mcand, mul_mplier[3:0]);
                    mul_state <= ooo_pkg::MUL_IDLE;
                end else begin
                    mul_acc    <= mul_acc + nibble_pp(mul_mcand, mul_mplier[3:0]);
                    mul_mcand  <= mul_mcand << 4;
                    mul_mplier <= mul_mplier >> 4;
                    mul_cnt    <= mul_cnt + 1'b1;
                end
            end
        end
    end

    // A tag is broadcast once per result, never held over a second cycle
    a_cdb_pulse: assert property (@(posedge clk) disable iff (rst)
        cdb_valid |=> !(cdb_valid && cdb_tag == $past(cdb_tag)))
        else $error("CDB repeated tag %0d", cdb_tag);

endmodule

//--- src/ooo_core.sv
`timescale 1ns/1ps
`include "ooo_macros.svh"

module ooo_core (
    input  logic                       clk,
    input  logic                       rst,
    // Issue port, program order
    input  logic                       issue_valid,
    output logic                       issue_ready,
    input  ooo_pkg::alu_op_t           issue_op,
    input  logic [`OOO_REG_ADDR_W-1:0] issue_rd,
    input  logic [`OOO_REG_ADDR_W-1:0] issue_rs1,
    input  logic [`OOO_REG_ADDR_W-1:0] issue_rs2,
    input  logic [`OOO_DATA_W-1:0]     issue_imm,
    output logic [`OOO_TAG_W-1:0]      issue_tag,
    // Broadcast, visible outside
    output logic                       cdb_valid,
    output logic [`OOO_TAG_W-1:0]      cdb_tag,
    output logic [`OOO_DATA_W-1:0]     cdb_value,
    // Register readout
    input  logic [`OOO_REG_ADDR_W-1:0] reg_addr,
    output logic [`OOO_DATA_W-1:0]     reg_data
);

    // ------------------------------------------------------------
    // Internal nets
    // ------------------------------------------------------------
    logic                   issue_fire;
    logic                   src1_ready, src2_ready;
    logic [`OOO_TAG_W-1:0]  src1_tag, src2_tag;
    logic [`OOO_DATA_W-1:0] src1_value, src2_value;
    logic                   disp_valid, disp_ready;
    ooo_pkg::alu_op_t       disp_op;
    logic [`OOO_DATA_W-1:0] disp_a, disp_b;
    logic [`OOO_TAG_W-1:0]  disp_tag;

    assign issue_fire = issue_valid && issue_ready;  // Rename only on a real transfer

    register_alias_table u_rat (
        .clk, .rst, .issue_fire, .issue_op, .issue_rd, .issue_rs1, .issue_rs2,
        .issue_imm, .issue_tag, .cdb_valid, .cdb_tag, .cdb_value,
        .src1_ready, .src1_tag, .src1_value, .src2_ready, .src2_tag, .src2_value,
        .reg_addr, .reg_data
    );

    reservation_station u_rs (
        .clk, .rst, .issue_valid, .issue_ready, .issue_tag, .issue_op,
        .src1_ready, .src1_tag, .src1_value, .src2_ready, .src2_tag, .src2_value,
        .cdb_valid, .cdb_tag, .cdb_value,
        .disp_valid, .disp_ready, .disp_op, .disp_a, .disp_b, .disp_tag
    );

    int_exec_unit u_exec (
        .clk, .rst, .disp_valid, .disp_ready, .disp_op, .disp_a, .disp_b, .disp_tag,
        .cdb_valid, .cdb_tag, .cdb_value
    );

endmodule

//--- src/ooo_macros.svh
`ifndef OOO_MACROS_SVH
`define OOO_MACROS_SVH

// ------------------------------------------------------------
// Datapath sizing
// ------------------------------------------------------------
`define OOO_DATA_W      16  // Operand and register width
`define OOO_NUM_REGS    8   // Architectural registers
`define OOO_REG_ADDR_W  3   // Register index width

// ------------------------------------------------------------
// Reservation station and tags
// ------------------------------------------------------------
`define OOO_RS_DEPTH    4   // Station entries
`define OOO_TAG_W       2   // Tag is the station entry index

// Iterative multiplier, 4 multiplier bits retired per step
`define OOO_MUL_STEPS   4

`endif

//--- src/ooo_pkg.sv
package ooo_pkg;

    // ------------------------------------------------------------
    // Integer unit opcodes
    // ------------------------------------------------------------
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,  // rd = rs1 + rs2
        OP_SUB = 3'd1,  // rd = rs1 - rs2
        OP_AND = 3'd2,  // rd = rs1 & rs2
        OP_XOR = 3'd3,  // rd = rs1 ^ rs2
        OP_MUL = 3'd4,  // Low half of rs1 * rs2, multi-cycle
        OP_LDI = 3'd5   // rd = imm
    } alu_op_t;

    // ------------------------------------------------------------
    // Multiplier sequencing
    // ------------------------------------------------------------
    typedef enum logic {
        MUL_IDLE = 1'b0,  // Free to accept a dispatch
        MUL_BUSY = 1'b1   // Shift-add in progress
    } mul_state_t;

endpackage

//--- src/register_alias_table.sv
`timescale 1ns/1ps
`include "ooo_macros.svh"

module register_alias_table (
    input  logic                       clk,
    input  logic                       rst,
    // Issue side
    input  logic                       issue_fire,
    input  ooo_pkg::alu_op_t           issue_op,
    input  logic [`OOO_REG_ADDR_W-1:0] issue_rd,
    input  logic [`OOO_REG_ADDR_W-1:0] issue_rs1,
    input  logic [`OOO_REG_ADDR_W-1:0] issue_rs2,
    input  logic [`OOO_DATA_W-1:0]     issue_imm,
    input  logic [`OOO_TAG_W-1:0]      issue_tag,
    // Common data bus
    input  logic                       cdb_valid,
    input  logic [`OOO_TAG_W-1:0]      cdb_tag,
    input  logic [`OOO_DATA_W-1:0]     cdb_value,
    // Operands toward the station
    output logic                       src1_ready,
    output logic [`OOO_TAG_W-1:0]      src1_tag,
    output logic [`OOO_DATA_W-1:0]     src1_value,
    output logic                       src2_ready,
    output logic [`OOO_TAG_W-1:0]      src2_tag,
    output logic [`OOO_DATA_W-1:0]     src2_value,
    // Register readout
    input  logic [`OOO_REG_ADDR_W-1:0] reg_addr,
    output logic [`OOO_DATA_W-1:0]     reg_data
);

    logic [`OOO_DATA_W-1:0]   regs [`OOO_NUM_REGS];  // Architectural values
    logic [`OOO_TAG_W-1:0]    tags [`OOO_NUM_REGS];  // Newest producer per register
    logic [`OOO_NUM_REGS-1:0] busy;                  // Producer still outstanding

    // Index 0 is rs1, index 1 is rs2
    logic [`OOO_REG_ADDR_W-1:0] src_addr [2];
    logic                       src_rdy  [2];
    logic [`OOO_TAG_W-1:0]      src_tag  [2];
    logic [`OOO_DATA_W-1:0]     src_val  [2];

    assign src_addr[0] = issue_rs1;
    assign src_addr[1] = issue_rs2;

    // ------------------------------------------------------------
    // Operand formation with CDB bypass
    // ------------------------------------------------------------
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            src_tag[s] = tags[src_addr[s]];
            if (!busy[src_addr[s]]) begin
                src_rdy[s] = 1'b1;                 // Value already in the file
                src_val[s] = regs[src_addr[s]];
            end else if (cdb_valid && cdb_tag == tags[src_addr[s]]) begin
                src_rdy[s] = 1'b1;                 // Producer broadcasting right now
                src_val[s] = cdb_value;
            end else begin
                src_rdy[s] = 1'b0;                 // Wait on the tag
                src_val[s] = '0;
            end
        end
        // LDI takes the immediate and needs no second source
        if (issue_op == ooo_pkg::OP_LDI) begin
            src_rdy[0] = 1'b1;
            src_val[0] = issue_imm;
            src_rdy[1] = 1'b1;
            src_val[1] = '0;
        end
    end

    assign src1_ready = src_rdy[0];
    assign src1_tag   = src_tag[0];
    assign src1_value = src_val[0];
    assign src2_ready = src_rdy[1];
    assign src2_tag   = src_tag[1];
    assign src2_value = src_val[1];

    // ------------------------------------------------------------
    // Writeback and renaming
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
            for (int r = 0; r < `OOO_NUM_REGS; r++) begin
                regs[r] <= '0;
                tags[r] <= '0;
            end
        end else begin
            // Only the newest producer may write, older ones are dropped (WAW)
            if (cdb_valid) begin
                for (int r = 0; r < `OOO_NUM_REGS; r++) begin
                    if (busy[r] && tags[r] == cdb_tag) begin
                        regs[r] <= cdb_value;
                        busy[r] <= 1'b0;
                    end
                end
            end
            // Later assignment, so a same-cycle rename wins over the clear
            if (issue_fire) begin
                tags[issue_rd] <= issue_tag;
                busy[issue_rd] <= 1'b1;
            end
        end
    end

    assign reg_data = regs[reg_addr];  // Architectural view only

    // Renaming an unknown register would corrupt the whole tag map
    a_rd_known: assert property (@(posedge clk) disable iff (rst)
        issue_fire |-> !$isunknown(issue_rd))
        else $error("issue_fire with unknown rd");

endmodule

//--- src/reservation_station.sv
`timescale 1ns/1ps
`include "ooo_macros.svh"

module reservation_station (
    input  logic                   clk,
    input  logic                   rst,
    // Issue handshake
    input  logic                   issue_valid,
    output logic                   issue_ready,
    output logic [`OOO_TAG_W-1:0]  issue_tag,
    input  ooo_pkg::alu_op_t       issue_op,
    // Operands from the alias table
    input  logic                   src1_ready,
    input  logic [`OOO_TAG_W-1:0]  src1_tag,
    input  logic [`OOO_DATA_W-1:0] src1_value,
    input  logic                   src2_ready,
    input  logic [`OOO_TAG_W-1:0]  src2_tag,
    input  logic [`OOO_DATA_W-1:0] src2_value,
    // Common data bus snoop
    input  logic                   cdb_valid,
    input  logic [`OOO_TAG_W-1:0]  cdb_tag,
    input  logic [`OOO_DATA_W-1:0] cdb_value,
    // Dispatch handshake
    output logic                   disp_valid,
    input  logic                   disp_ready,
    output ooo_pkg::alu_op_t       disp_op,
    output logic [`OOO_DATA_W-1:0] disp_a,
    output logic [`OOO_DATA_W-1:0] disp_b,
    output logic [`OOO_TAG_W-1:0]  disp_tag
);

    // Control state per entry
    logic [`OOO_RS_DEPTH-1:0] e_valid;     // Holds an instruction
    logic [`OOO_RS_DEPTH-1:0] e_inflight;  // Dispatched, result not yet broadcast
    logic [`OOO_RS_DEPTH-1:0] e_rdy1;
    logic [`OOO_RS_DEPTH-1:0] e_rdy2;
    // Payload per entry
    ooo_pkg::alu_op_t         e_op   [`OOO_RS_DEPTH];
    logic [`OOO_TAG_W-1:0]    e_tag1 [`OOO_RS_DEPTH];
    logic [`OOO_TAG_W-1:0]    e_tag2 [`OOO_RS_DEPTH];
    logic [`OOO_DATA_W-1:0]   e_val1 [`OOO_RS_DEPTH];
    logic [`OOO_DATA_W-1:0]   e_val2 [`OOO_RS_DEPTH];

    logic                     any_free;
    logic [`OOO_TAG_W-1:0]    alloc_idx;
    logic                     any_ready;
    logic [`OOO_TAG_W-1:0]    disp_idx;
    logic                     issue_fire;
    logic                     disp_fire;

    // ------------------------------------------------------------
    // Lowest free entry and lowest ready entry
    // ------------------------------------------------------------
    always_comb begin
        any_free  = 1'b0;
        alloc_idx = '0;
        any_ready = 1'b0;
        disp_idx  = '0;
        // Walk downward so the lowest index is the last one kept
        for (int i = `OOO_RS_DEPTH - 1; i >= 0; i--) begin
            // A tag stays reserved until its broadcast has been seen
            if (!e_valid[i] && !e_inflight[i]) begin
                any_free  = 1'b1;
                alloc_idx = `OOO_TAG_W'(i);
            end
            if (e_valid[i] && e_rdy1[i] && e_rdy2[i]) begin
                any_ready = 1'b1;
                disp_idx  = `OOO_TAG_W'(i);
            end
        end
    end

    assign issue_ready = any_free;
    assign issue_tag   = alloc_idx;
    assign issue_fire  = issue_valid && any_free;

    assign disp_valid  = any_ready;
    assign disp_op     = e_op[disp_idx];
    assign disp_a      = e_val1[disp_idx];
    assign disp_b      = e_val2[disp_idx];
    assign disp_tag    = disp_idx;
    assign disp_fire   = any_ready && disp_ready;

    // ------------------------------------------------------------
    // Payload: allocation and CDB capture
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (issue_fire) begin
            e_op[alloc_idx]   <= issue_op;
            e_tag1[alloc_idx] <= src1_tag;
            e_tag2[alloc_idx] <= src2_tag;
            e_val1[alloc_idx] <= src1_value;
            e_val2[alloc_idx] <= src2_value;
        end
        for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
            if (cdb_valid && e_valid[i] && !e_rdy1[i] && e_tag1[i] == cdb_tag)
                e_val1[i] <= cdb_value;
            if (cdb_valid && e_valid[i] && !e_rdy2[i] && e_tag2[i] == cdb_tag)
                e_val2[i] <= cdb_value;
        end
    end

    // ------------------------------------------------------------
    // Control: valid, ready bits, in-flight tracking
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            e_valid    <= '0;
            e_inflight <= '0;
            e_rdy1     <= '0;
            e_rdy2     <= '0;
        end else begin
            for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
                if (cdb_valid && e_valid[i] && e_tag1[i] == cdb_tag)
                    e_rdy1[i] <= 1'b1;  // Operand 1 captured
                if (cdb_valid && e_valid[i] && e_tag2[i] == cdb_tag)
                    e_rdy2[i] <= 1'b1;  // Operand 2 captured
            end
            if (cdb_valid)
                e_inflight[cdb_tag] <= 1'b0;  // Tag retired, entry reusable
            if (disp_fire) begin
                e_valid[disp_idx]    <= 1'b0;
                e_inflight[disp_idx] <= 1'b1;
            end
            if (issue_fire) begin
                e_valid[alloc_idx] <= 1'b1;
                e_rdy1[alloc_idx]  <= src1_ready;
                e_rdy2[alloc_idx]  <= src2_ready;
            end
        end
    end

    // Dispatched entry is gone on the next edge and not refilled while in flight
    a_disp_frees: assert property (@(posedge clk) disable iff (rst)
        disp_fire |=> !e_valid[$past(disp_idx)] && e_inflight[$past(disp_idx)])
        else $error("dispatched entry not retired");

    a_full_blocks: assert property (@(posedge clk) disable iff (rst)
        (&e_valid) |-> !issue_ready)
        else $error("issue_ready high with a full station");

endmodule

//--- tb/ooo_checker.sv
`timescale 1ns/1ps
`include "ooo_macros.svh"

module ooo_checker (
    input  logic                       clk,
    input  logic                       rst,
    // Issue port, observed only
    input  logic                       issue_valid,
    input  logic                       issue_ready,
    input  ooo_pkg::alu_op_t           issue_op,
    input  logic [`OOO_REG_ADDR_W-1:0] issue_rd,
    input  logic [`OOO_REG_ADDR_W-1:0] issue_rs1,
    input  logic [`OOO_REG_ADDR_W-1:0] issue_rs2,
    input  logic [`OOO_DATA_W-1:0]     issue_imm,
    input  logic [`OOO_TAG_W-1:0]      issue_tag,
    // Broadcast and readout
    input  logic                       cdb_valid,
    input  logic [`OOO_TAG_W-1:0]      cdb_tag,
    input  logic [`OOO_DATA_W-1:0]     cdb_value,
    input  logic [`OOO_REG_ADDR_W-1:0] reg_addr,
    input  logic [`OOO_DATA_W-1:0]     reg_data,
    input  logic                       readout_en,  // Compare reg_data on this edge
    // Counts back to the testbench
    output int                         checks,
    output int                         errors,
    output int                         issues,
    output int                         broadcasts,
    output int                         stalls,      // Cycles with issue held off
    output int                         outstanding, // Issued, not yet broadcast
    output int                         overtakes    // Results ahead of an older MUL
);

    logic [`OOO_DATA_W-1:0]   model      [`OOO_NUM_REGS];  // In-order register file
    logic [`OOO_DATA_W-1:0]   expect_val [`OOO_RS_DEPTH];  // Expected result per tag
    logic [`OOO_RS_DEPTH-1:0] pending;
    logic [`OOO_RS_DEPTH-1:0] is_mul;                      // Tag holds a MUL
    logic [`OOO_RS_DEPTH-1:0] older_mul  [`OOO_RS_DEPTH];  // MULs outstanding at issue
    logic                     after_reset;
    logic [`OOO_DATA_W-1:0]   res;
    int n_checks = 0, n_errors = 0, n_issues = 0, n_bcasts = 0, n_stalls = 0;
    int n_overtakes = 0;

    // Result of one instruction from the opcode definitions
    function automatic logic [`OOO_DATA_W-1:0] expected_result(
        input ooo_pkg::alu_op_t       op,
        input logic [`OOO_DATA_W-1:0] a,
        input logic [`OOO_DATA_W-1:0] b,
        input logic [`OOO_DATA_W-1:0] imm
    );
        case (op)
            ooo_pkg::OP_ADD: return a + b;
            ooo_pkg::OP_SUB: return a - b;
            ooo_pkg::OP_AND: return a & b;
            ooo_pkg::OP_XOR: return a ^ b;
            ooo_pkg::OP_MUL: return a * b;  // Low half only
            ooo_pkg::OP_LDI: return imm;
            default:         return 'x;
        endcase
    endfunction

    task automatic report(input bit ok, input string msg);
        n_checks++;
        if (ok) begin
            $display("[%0t] %s ok", $time, msg);
        end else begin
            n_errors++;
            $display("CHECK FAILED at %0t: %s", $time, msg);
        end
    endtask

    // ------------------------------------------------------------
    // Sampled on the rising edge, all DUT state is pre-edge here
    // ------------------------------------------------------------
    always @(posedge clk) begin
        if (rst) begin
            pending     = '0;
            is_mul      = '0;
            after_reset = 1'b1;
            for (int r = 0; r < `OOO_NUM_REGS; r++)
                model[r] = '0;
        end else begin
            if (after_reset) begin  // First cycle out of reset
                report(issue_ready === 1'b1 && cdb_valid === 1'b0,
                       "reset state issue_ready=1 cdb_valid=0");
                after_reset = 1'b0;
            end
            // Broadcast retires before a same-edge issue reuses the tag
            if (cdb_valid) begin
                n_bcasts++;
                if (!pending[cdb_tag]) begin
                    n_errors++;
                    $display("Broadcast at %0t on tag %0d with no instruction issued under it",
                             $time, cdb_tag);
                end else begin
                    report(cdb_value === expect_val[cdb_tag],
                           $sformatf("cdb tag %0d value %h expected %h",
                                     cdb_tag, cdb_value, expect_val[cdb_tag]));
                    if (!is_mul[cdb_tag] && |(older_mul[cdb_tag] & pending & is_mul))
                        n_overtakes++;  // Done while an older MUL still waits
                end
                pending[cdb_tag] = 1'b0;
            end
            if (issue_valid && issue_ready) begin
                res = expected_result(issue_op, model[issue_rs1], model[issue_rs2], issue_imm);
                expect_val[issue_tag] = res;
                older_mul[issue_tag]  = pending & is_mul;
                is_mul[issue_tag]     = (issue_op == ooo_pkg::OP_MUL);
                pending[issue_tag]    = 1'b1;
                model[issue_rd]       = res;  // Program order, so newest write wins
                n_issues++;
            end else if (issue_valid) begin
                n_stalls++;                   // Held off by a full station
            end
            if (readout_en)
                report(reg_data === model[reg_addr],
                       $sformatf("r%0d reads %h expected %h",
                                 reg_addr, reg_data, model[reg_addr]));
        end
        // Published after the edge so the testbench reads settled counts
        checks      <= n_checks;
        errors      <= n_errors;
        issues      <= n_issues;
        broadcasts  <= n_bcasts;
        stalls      <= n_stalls;
        outstanding <= $countones(pending);
        overtakes   <= n_overtakes;
    end

endmodule

//--- tb/tb_ooo_core.sv
`timescale 1ns/1ps
`include "ooo_macros.svh"

module tb_ooo_core;

    localparam int ROWS    = 22;
    localparam int TIMEOUT = ROWS * (`OOO_MUL_STEPS + 4) * 4;  // In cycles

    logic                       clk, rst;
    logic                       issue_valid, issue_ready;
    ooo_pkg::alu_op_t           issue_op;
    logic [`OOO_REG_ADDR_W-1:0] issue_rd, issue_rs1, issue_rs2, reg_addr;
    logic [`OOO_DATA_W-1:0]     issue_imm, cdb_value, reg_data;
    logic [`OOO_TAG_W-1:0]      issue_tag, cdb_tag;
    logic                       cdb_valid, readout_en;
    int     checks, errors, issues, broadcasts, stalls, outstanding, overtakes;
    int     cycles = 0;
    integer seed;

    // Instruction table, one row per instruction
    ooo_pkg::alu_op_t           t_op  [ROWS];
    logic [`OOO_REG_ADDR_W-1:0] t_rd  [ROWS], t_rs1 [ROWS], t_rs2 [ROWS];
    logic [`OOO_DATA_W-1:0]     t_imm [ROWS];
    bit                         t_gap [ROWS];  // Random idle cycles allowed before it

    ooo_core    uut (.*);
    ooo_checker chk (.*);

    always #2 clk = ~clk;  // 4 ns period

    task automatic load_row(input int i, input ooo_pkg::alu_op_t op, input int rd,
                            input int rs1, input int rs2, input int imm, input bit gap);
        t_op[i]  = op;
        t_rd[i]  = rd;
        t_rs1[i] = rs1;
        t_rs2[i] = rs2;
        t_imm[i] = imm;
        t_gap[i] = gap;
    endtask

    // One register per cycle, the checker compares on each edge
    task automatic read_all_regs();
        for (int r = 0; r < `OOO_NUM_REGS; r++) begin
            reg_addr   <= `OOO_REG_ADDR_W'(r);
            readout_en <= 1'b1;
            @(posedge clk);
        end
        readout_en <= 1'b0;
        @(posedge clk);
    endtask

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    initial begin
        int gap;
        seed = 36290;
        clk = 1'b0;
        rst = 1'b1;
        issue_valid = 1'b0;
        issue_op    = ooo_pkg::OP_ADD;
        issue_rd    = '0;
        issue_rs1   = '0;
        issue_rs2   = '0;
        issue_imm   = '0;
        reg_addr    = '0;
        readout_en  = 1'b0;
        load_row(0,  ooo_pkg::OP_LDI, 1, 0, 0, 16'h0005, 1);
        load_row(1,  ooo_pkg::OP_LDI, 2, 0, 0, 16'h0003, 1);
        load_row(2,  ooo_pkg::OP_ADD, 3, 1, 2, 0, 1);
        load_row(3,  ooo_pkg::OP_SUB, 4, 1, 2, 0, 1);
        load_row(4,  ooo_pkg::OP_AND, 5, 1, 2, 0, 1);
        load_row(5,  ooo_pkg::OP_XOR, 6, 1, 2, 0, 1);
        load_row(6,  ooo_pkg::OP_LDI, 7, 0, 0, 16'h1234, 1);
        load_row(7,  ooo_pkg::OP_MUL, 3, 7, 2, 0, 1);       // RAW chain head
        load_row(8,  ooo_pkg::OP_ADD, 4, 3, 1, 0, 0);       // Back to back, fills station
        load_row(9,  ooo_pkg::OP_SUB, 5, 3, 2, 0, 0);
        load_row(10, ooo_pkg::OP_XOR, 6, 3, 4, 0, 0);
        load_row(11, ooo_pkg::OP_AND, 1, 3, 7, 0, 0);
        load_row(12, ooo_pkg::OP_ADD, 2, 5, 6, 0, 0);
        load_row(13, ooo_pkg::OP_MUL, 0, 7, 2, 0, 0);       // First write of r0, waits on r2
        load_row(14, ooo_pkg::OP_LDI, 5, 0, 0, 16'h00ff, 0); // Independent of the MUL
        load_row(15, ooo_pkg::OP_XOR, 6, 5, 2, 0, 0);
        load_row(16, ooo_pkg::OP_ADD, 0, 5, 5, 0, 0);       // WAW on r0
        load_row(17, ooo_pkg::OP_MUL, 4, 4, 1, 0, 1);
        load_row(18, ooo_pkg::OP_SUB, 7, 1, 4, 0, 0);
        load_row(19, ooo_pkg::OP_LDI, 2, 0, 0, 16'hbeef, 1);
        load_row(20, ooo_pkg::OP_AND, 3, 2, 7, 0, 1);
        load_row(21, ooo_pkg::OP_XOR, 1, 3, 0, 0, 1);

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        read_all_regs();  // Everything zero out of reset

        for (int i = 0; i < ROWS; i++) begin
            if (t_gap[i]) begin
                gap = $random(seed) & 3;
                if (gap > 0) begin
                    issue_valid <= 1'b0;
                    repeat (gap) @(posedge clk);
                end
            end
            issue_valid <= 1'b1;
            issue_op    <= t_op[i];
            issue_rd    <= t_rd[i];
            issue_rs1   <= t_rs1[i];
            issue_rs2   <= t_rs2[i];
            issue_imm   <= t_imm[i];
            do @(negedge clk); while (!issue_ready);  // Settled ready mid-cycle
            @(posedge clk);                           // Taken on this edge
        end
        issue_valid <= 1'b0;
        @(posedge clk);
        while (outstanding != 0)  // Drain every issued tag
            @(posedge clk);
        read_all_regs();

        $display("Summary: %0d checks, %0d errors, %0d issues, %0d broadcasts, %0d stall cycles",
                 checks, errors, issues, broadcasts, stalls);
        if (issues != ROWS)
            $display("Only %0d of %0d instructions were accepted", issues, ROWS);
        if (broadcasts != issues)
            $display("Broadcast count %0d does not match issue count %0d", broadcasts, issues);
        if (stalls == 0)
            $display("issue_ready never dropped while the station was full");
        if (overtakes == 0)
            $display("No instruction finished ahead of an older MUL");
        if (errors == 0 && issues == ROWS && broadcasts == issues && stalls > 0 &&
            overtakes > 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

    // Limit scales with table length and multiplier latency
    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("Run hung: not finished after %0d cycles", cycles);
            $display("Verification failed");
            $finish;
        end
    end

endmodule
